// File: src.f
src/dispatch_pkg.sv
src/regfile.sv
src/reg_status_table.sv
src/tag_fifo.sv
src/inst_decoder.sv
src/dispatch.sv
tests/dispatch_tb.sv

// File: run.sh
#!/bin/sh
# Builds the dispatch testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module dispatch_tb \
   --Mdir obj_dir -o dispatch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/dispatch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
exit 0

// File: tests/dispatch_tb.sv
module dispatch_tb;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int tag_width    = 3;
   localparam int clk_half     = 20;
   localparam int sample_delay = 15;
   localparam int reset_cycles = 16;
   // The directed tests take about 100 cycles after reset, so this is a wide margin
   localparam int max_cycles   = 2000;

   localparam logic [3:0] en_none = 4'b0000;
   localparam logic [3:0] en_int  = 4'b1000;
   localparam logic [3:0] en_ls   = 4'b0100;
   localparam logic [3:0] en_mult = 4'b0010;
   localparam logic [3:0] en_div  = 4'b0001;

   localparam logic [5:0] fn_add  = 6'd32;
   localparam logic [5:0] fn_mult = 6'd24;
   localparam logic [5:0] fn_div  = 6'd26;
   localparam logic [5:0] opc_beq = 6'd4;
   localparam logic [5:0] opc_bne = 6'd5;
   localparam logic [5:0] opc_lw  = 6'd35;
   localparam logic [5:0] opc_sw  = 6'd43;

   logic                   clk;
   logic                   reset;
   logic [31:0]            ifq_inst;
   logic [31:0]            ifq_pc_plus4;
   logic                   ifq_empty;
   logic                   ifq_ren;
   logic                   ifq_branch_valid;
   logic [31:0]            ifq_branch_addr;
   logic                   cdb_valid;
   logic [tag_width-1:0]   cdb_tag;
   logic [31:0]            cdb_data;
   logic                   cdb_branch;
   logic                   cdb_branch_taken;
   logic [15:0]            equeue_imm;
   logic [tag_width-1:0]   equeue_rdtag;
   logic [tag_width-1:0]   equeue_rstag;
   logic [tag_width-1:0]   equeue_rttag;
   logic [31:0]            equeue_rsdata;
   logic [31:0]            equeue_rtdata;
   logic                   equeue_rsvalid;
   logic                   equeue_rtvalid;
   logic                   equeue_int_en;
   logic [5:0]             equeue_int_opcode;
   logic                   equeue_ls_en;
   dispatch_pkg::ls_op_e   equeue_ls_opcode;
   logic                   equeue_mult_en;
   logic                   equeue_div_en;
   logic                   equeue_int_ready;
   logic                   equeue_ls_ready;
   logic                   equeue_mult_ready;
   logic                   equeue_div_ready;
   logic [4:0]             debug_regfile_addr;
   logic [31:0]            debug_regfile_data;

   int errors;
   int cycle_count;

   // Reference model of the rename state
   bit                   model_busy [32];
   logic [tag_width-1:0] model_tag  [32];
   logic [31:0]          model_val  [32];
   logic [tag_width-1:0] free_tags  [$];

   dispatch #(.tag_width(tag_width)) uut (
      .clk(clk), .reset(reset),
      .ifq_inst(ifq_inst), .ifq_pc_plus4(ifq_pc_plus4), .ifq_empty(ifq_empty),
      .ifq_ren(ifq_ren), .ifq_branch_valid(ifq_branch_valid),
      .ifq_branch_addr(ifq_branch_addr),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
      .cdb_branch(cdb_branch), .cdb_branch_taken(cdb_branch_taken),
      .equeue_imm(equeue_imm), .equeue_rdtag(equeue_rdtag),
      .equeue_rstag(equeue_rstag), .equeue_rttag(equeue_rttag),
      .equeue_rsdata(equeue_rsdata), .equeue_rtdata(equeue_rtdata),
      .equeue_rsvalid(equeue_rsvalid), .equeue_rtvalid(equeue_rtvalid),
      .equeue_int_en(equeue_int_en), .equeue_int_opcode(equeue_int_opcode),
      .equeue_ls_en(equeue_ls_en), .equeue_ls_opcode(equeue_ls_opcode),
      .equeue_mult_en(equeue_mult_en), .equeue_div_en(equeue_div_en),
      .equeue_int_ready(equeue_int_ready), .equeue_ls_ready(equeue_ls_ready),
      .equeue_mult_ready(equeue_mult_ready), .equeue_div_ready(equeue_div_ready),
      .debug_regfile_addr(debug_regfile_addr), .debug_regfile_data(debug_regfile_data)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] funct);
      return {6'd0, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jump_word(input logic [25:0] addr);
      return {6'd2, addr};
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         errors++;
      end
   endtask

   task automatic check_strobes(input logic ren, input logic [3:0] en);
      check_value("ifq_ren", 32'(ifq_ren), 32'(ren));
      check_value("equeue_{int,ls,mult,div}_en",
                  32'({equeue_int_en, equeue_ls_en, equeue_mult_en, equeue_div_en}), 32'(en));
   endtask

   // A busy operand is resolved only by a CDB broadcast of its own tag
   task automatic check_operand(input string which, input logic [4:0] r, input logic valid,
                                input logic [31:0] data, input logic [tag_width-1:0] tag);
      bit hit;
      bit exp_valid;
      hit       = cdb_valid && model_busy[r] && (model_tag[r] == cdb_tag);
      exp_valid = !model_busy[r] || hit;
      check_value({"equeue_", which, "valid"}, 32'(valid), 32'(exp_valid));
      if (exp_valid) begin
         check_value({"equeue_", which, "data"}, data, hit ? cdb_data : model_val[r]);
      end else begin
         check_value({"equeue_", which, "tag"}, 32'(tag), 32'(model_tag[r]));
      end
   endtask

   task automatic check_dispatch(input logic [3:0] en, input logic [4:0] rs,
                                 input logic [4:0] rt, input bit needs_tag, input bit is_load);
      check_strobes(1'b1, en);
      check_operand("rs", rs, equeue_rsvalid, equeue_rsdata, equeue_rstag);
      if (is_load) begin
         check_value("equeue_rtvalid", 32'(equeue_rtvalid), 32'd1);
      end else begin
         check_operand("rt", rt, equeue_rtvalid, equeue_rtdata, equeue_rttag);
      end
      if (needs_tag) begin
         check_value("equeue_rdtag", 32'(equeue_rdtag), 32'(free_tags[0]));
      end
   endtask

   task automatic present(input logic [31:0] inst, input logic [31:0] pc);
      ifq_inst     = inst;
      ifq_pc_plus4 = pc;
      ifq_empty    = 1'b0;
   endtask

   // Applies the clock edge to the model, then idles the IFQ and CDB on the falling edge
   task automatic commit(input bit dispatched, input logic [4:0] dest, input bit needs_tag);
      logic [tag_width-1:0] new_tag;
      new_tag = '0;
      if (free_tags.size() > 0) begin
         new_tag = free_tags[0];
      end
      @(posedge clk);
      if (cdb_valid) begin
         for (int i = 1; i < 32; i++) begin
            if (model_busy[i] && (model_tag[i] == cdb_tag)) begin
               model_busy[i] = 1'b0;
               model_val[i]  = cdb_data;
            end
         end
      end
      if (dispatched && needs_tag) begin
         void'(free_tags.pop_front());
         if (dest != 5'd0) begin
            model_busy[dest] = 1'b1;
            model_tag[dest]  = new_tag;
         end
      end
      if (cdb_valid) begin
         free_tags.push_back(cdb_tag);
      end
      @(negedge clk);
      ifq_empty        = 1'b1;
      cdb_valid        = 1'b0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
   endtask

   task automatic test_reset_state();
      logic [31:0] inst;
      inst = rtype_word(5'd2, 5'd3, 5'd1, fn_add);
      for (int a = 0; a < 32; a++) begin
         debug_regfile_addr = 5'(a);
         #1;
         check_value("debug_regfile_data", debug_regfile_data, 32'd0);
         @(negedge clk);
      end
      // A valid word on the bus must be ignored while the IFQ is empty
      ifq_inst = inst;
      #sample_delay;
      check_strobes(1'b0, en_none);
      check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd0);
      @(negedge clk);
      present(inst, 32'h0000_0100);
      #sample_delay;
      check_dispatch(en_int, 5'd2, 5'd3, 1'b1, 1'b0);
      check_value("equeue_rdtag", 32'(equeue_rdtag), 32'd0);
      check_value("equeue_int_opcode", 32'(equeue_int_opcode), 32'(fn_add));
      commit(1'b1, 5'd1, 1'b1);
   endtask

   task automatic test_writeback_forward();
      logic [tag_width-1:0] t;
      logic [31:0]          x;
      logic [31:0]          use_r1;
      t = free_tags[0];
      present(rtype_word(5'd4, 5'd5, 5'd1, fn_add), 32'h0000_0104);
      #sample_delay;
      check_dispatch(en_int, 5'd4, 5'd5, 1'b1, 1'b0);
      commit(1'b1, 5'd1, 1'b1);
      use_r1 = rtype_word(5'd1, 5'd1, 5'd3, fn_add);
      x      = $urandom;
      present(use_r1, 32'h0000_0108);
      equeue_int_ready = 1'b0;
      #sample_delay;
      check_strobes(1'b0, en_none);
      check_value("equeue_rstag", 32'(equeue_rstag), 32'(t));
      check_value("equeue_rsvalid", 32'(equeue_rsvalid), 32'd0);
      check_value("equeue_rttag", 32'(equeue_rttag), 32'(t));
      check_value("equeue_rtvalid", 32'(equeue_rtvalid), 32'd0);
      commit(1'b0, 5'd0, 1'b0);
      present(use_r1, 32'h0000_0108);
      equeue_int_ready = 1'b1;
      cdb_valid        = 1'b1;
      cdb_tag          = t;
      cdb_data         = x;
      #sample_delay;
      check_dispatch(en_int, 5'd1, 5'd1, 1'b1, 1'b0);
      check_value("equeue_rsdata", equeue_rsdata, x);
      check_value("equeue_rtdata", equeue_rtdata, x);
      commit(1'b1, 5'd3, 1'b1);
      debug_regfile_addr = 5'd1;
      #1;
      check_value("debug_regfile_data", debug_regfile_data, x);
      @(negedge clk);
   endtask

   task automatic test_routing();
      logic [15:0]          imm;
      logic [tag_width-1:0] head;
      present(rtype_word(5'd1, 5'd2, 5'd6, fn_mult), 32'h0000_0200);
      #sample_delay;
      check_dispatch(en_mult, 5'd1, 5'd2, 1'b1, 1'b0);
      commit(1'b1, 5'd6, 1'b1);
      present(rtype_word(5'd6, 5'd1, 5'd7, fn_div), 32'h0000_0204);
      #sample_delay;
      check_dispatch(en_div, 5'd6, 5'd1, 1'b1, 1'b0);
      commit(1'b1, 5'd7, 1'b1);
      // The load targets a busy register, yet its rt operand is always valid
      imm = 16'($urandom);
      present(itype_word(opc_lw, 5'd1, 5'd3, imm), 32'h0000_0208);
      #sample_delay;
      check_dispatch(en_ls, 5'd1, 5'd3, 1'b1, 1'b1);
      check_value("equeue_ls_opcode", 32'(equeue_ls_opcode), 32'(dispatch_pkg::ls_lw));
      check_value("equeue_imm", 32'(equeue_imm), 32'(imm));
      commit(1'b1, 5'd3, 1'b1);
      head = free_tags[0];
      present(itype_word(opc_sw, 5'd1, 5'd6, 16'($urandom)), 32'h0000_020c);
      #sample_delay;
      check_dispatch(en_ls, 5'd1, 5'd6, 1'b0, 1'b0);
      check_value("equeue_ls_opcode", 32'(equeue_ls_opcode), 32'(dispatch_pkg::ls_sw));
      commit(1'b1, 5'd0, 1'b0);
      present(itype_word(opc_sw, 5'd0, 5'd7, 16'($urandom)), 32'h0000_0210);
      #sample_delay;
      check_dispatch(en_ls, 5'd0, 5'd7, 1'b0, 1'b0);
      check_value("equeue_rdtag", 32'(equeue_rdtag), 32'(head));
      commit(1'b1, 5'd0, 1'b0);
   endtask

   task automatic test_backpressure();
      logic [31:0] inst;
      inst = rtype_word(5'd1, 5'd0, 5'd9, fn_mult);
      equeue_mult_ready = 1'b0;
      for (int i = 0; i < 4; i++) begin
         present(inst, 32'h0000_0300);
         #sample_delay;
         check_strobes(1'b0, en_none);
         commit(1'b0, 5'd0, 1'b0);
      end
      present(inst, 32'h0000_0300);
      equeue_mult_ready = 1'b1;
      #sample_delay;
      check_dispatch(en_mult, 5'd1, 5'd0, 1'b1, 1'b0);
      commit(1'b1, 5'd9, 1'b1);
   endtask

   task automatic test_jump_branch();
      logic [25:0] addr;
      logic [15:0] imm;
      logic [31:0] pc;
      logic [31:0] target;
      pc   = 32'ha000_0040;
      addr = 26'($urandom);
      present(jump_word(addr), pc);
      #sample_delay;
      check_strobes(1'b1, en_none);
      check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd1);
      check_value("ifq_branch_addr", ifq_branch_addr, {pc[31:28], addr, 2'b00});
      commit(1'b1, 5'd0, 1'b0);
      pc     = 32'h0000_2000;
      imm    = 16'($urandom);
      target = pc + {{14{imm[15]}}, imm, 2'b00};
      present(itype_word(opc_beq, 5'd1, 5'd0, imm), pc);
      #sample_delay;
      check_dispatch(en_int, 5'd1, 5'd0, 1'b0, 1'b0);
      check_value("equeue_int_opcode", 32'(equeue_int_opcode), 32'(opc_beq));
      commit(1'b1, 5'd0, 1'b0);
      for (int i = 0; i < 3; i++) begin
         present(rtype_word(5'd1, 5'd1, 5'd10, fn_add), 32'h0000_2004);
         #sample_delay;
         check_strobes(1'b0, en_none);
         check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd0);
         commit(1'b0, 5'd0, 1'b0);
      end
      present(rtype_word(5'd1, 5'd1, 5'd10, fn_add), 32'h0000_2004);
      cdb_branch       = 1'b1;
      cdb_branch_taken = 1'b1;
      #sample_delay;
      check_strobes(1'b0, en_none);
      check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd1);
      check_value("ifq_branch_addr", ifq_branch_addr, target);
      commit(1'b0, 5'd0, 1'b0);
      present(rtype_word(5'd1, 5'd1, 5'd10, fn_add), target + 32'd4);
      #sample_delay;
      check_dispatch(en_int, 5'd1, 5'd1, 1'b1, 1'b0);
      commit(1'b1, 5'd10, 1'b1);
      // Not-taken outcome releases the stall without a redirect
      present(itype_word(opc_bne, 5'd10, 5'd1, 16'($urandom)), 32'h0000_3000);
      #sample_delay;
      check_dispatch(en_int, 5'd10, 5'd1, 1'b0, 1'b0);
      check_value("equeue_int_opcode", 32'(equeue_int_opcode), 32'(opc_bne));
      commit(1'b1, 5'd0, 1'b0);
      present(rtype_word(5'd1, 5'd1, 5'd11, fn_add), 32'h0000_3004);
      #sample_delay;
      check_strobes(1'b0, en_none);
      commit(1'b0, 5'd0, 1'b0);
      present(rtype_word(5'd1, 5'd1, 5'd11, fn_add), 32'h0000_3004);
      cdb_branch = 1'b1;
      #sample_delay;
      check_strobes(1'b0, en_none);
      check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd0);
      commit(1'b0, 5'd0, 1'b0);
      present(rtype_word(5'd1, 5'd1, 5'd11, fn_add), 32'h0000_3004);
      #sample_delay;
      check_dispatch(en_int, 5'd1, 5'd1, 1'b1, 1'b0);
      commit(1'b1, 5'd11, 1'b1);
   endtask

   task automatic test_tag_exhaustion();
      logic [31:0] y;
      while (free_tags.size() > 0) begin
         present(rtype_word(5'd0, 5'd0, 5'd13, fn_add), 32'h0000_4000);
         #sample_delay;
         check_dispatch(en_int, 5'd0, 5'd0, 1'b1, 1'b0);
         commit(1'b1, 5'd13, 1'b1);
      end
      for (int i = 0; i < 2; i++) begin
         present(rtype_word(5'd1, 5'd1, 5'd12, fn_add), 32'h0000_4004);
         #sample_delay;
         check_strobes(1'b0, en_none);
         commit(1'b0, 5'd0, 1'b0);
      end
      // The freed tag only becomes available after the broadcast edge
      y = $urandom;
      present(rtype_word(5'd1, 5'd1, 5'd12, fn_add), 32'h0000_4004);
      cdb_valid = 1'b1;
      cdb_tag   = 3'd5;
      cdb_data  = y;
      #sample_delay;
      check_strobes(1'b0, en_none);
      commit(1'b0, 5'd0, 1'b0);
      present(rtype_word(5'd1, 5'd1, 5'd12, fn_add), 32'h0000_4004);
      #sample_delay;
      check_dispatch(en_int, 5'd1, 5'd1, 1'b1, 1'b0);
      check_value("equeue_rdtag", 32'(equeue_rdtag), 32'd5);
      commit(1'b1, 5'd12, 1'b1);
      debug_regfile_addr = 5'd3;
      #1;
      check_value("debug_regfile_data", debug_regfile_data, y);
   endtask

   initial begin
      void'($urandom(15091));
      errors             = 0;
      cycle_count        = 0;
      reset              = 1'b1;
      ifq_inst           = '0;
      ifq_pc_plus4       = '0;
      ifq_empty          = 1'b1;
      cdb_valid          = 1'b0;
      cdb_tag            = '0;
      cdb_data           = '0;
      cdb_branch         = 1'b0;
      cdb_branch_taken   = 1'b0;
      equeue_int_ready   = 1'b1;
      equeue_ls_ready    = 1'b1;
      equeue_mult_ready  = 1'b1;
      equeue_div_ready   = 1'b1;
      debug_regfile_addr = '0;
      for (int i = 0; i < 32; i++) begin
         model_busy[i] = 1'b0;
         model_tag[i]  = '0;
         model_val[i]  = '0;
      end
      for (int i = 0; i < 2 ** tag_width; i++) begin
         free_tags.push_back(tag_width'(i));
      end
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      test_reset_state();
      test_writeback_forward();
      test_routing();
      test_backpressure();
      test_jump_branch();
      test_tag_exhaustion();
      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: src/dispatch.sv
module dispatch #(
   parameter int tag_width = 6
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [31:0]                             ifq_inst,
   input  logic [31:0]                             ifq_pc_plus4,
   input  logic                                    ifq_empty,
   output logic                                    ifq_ren,
   output logic                                    ifq_branch_valid,
   output logic [31:0]                             ifq_branch_addr,
   input  logic                                    cdb_valid,
   input  logic [tag_width-1:0]                    cdb_tag,
   input  logic [dispatch_pkg::data_width-1:0]     cdb_data,
   input  logic                                    cdb_branch,
   input  logic                                    cdb_branch_taken,
   output logic [dispatch_pkg::imm_width-1:0]      equeue_imm,
   output logic [tag_width-1:0]                    equeue_rdtag,
   output logic [tag_width-1:0]                    equeue_rstag,
   output logic [tag_width-1:0]                    equeue_rttag,
   output logic [dispatch_pkg::data_width-1:0]     equeue_rsdata,
   output logic [dispatch_pkg::data_width-1:0]     equeue_rtdata,
   output logic                                    equeue_rsvalid,
   output logic                                    equeue_rtvalid,
   output logic                                    equeue_int_en,
   output logic [dispatch_pkg::opcode_width-1:0]   equeue_int_opcode,
   output logic                                    equeue_ls_en,
   output dispatch_pkg::ls_op_e                    equeue_ls_opcode,
   output logic                                    equeue_mult_en,
   output logic                                    equeue_div_en,
   input  logic                                    equeue_int_ready,
   input  logic                                    equeue_ls_ready,
   input  logic                                    equeue_mult_ready,
   input  logic                                    equeue_div_ready,
   input  logic [dispatch_pkg::reg_addr_width-1:0] debug_regfile_addr,
   output logic [dispatch_pkg::data_width-1:0]     debug_regfile_data
);
   import dispatch_pkg::*;

   dispatch_state_e state;
   dispatch_state_e next_state;
   logic [31:0]     branch_target_r;

   logic [reg_addr_width-1:0] dec_rs_addr, dec_rt_addr, dec_dest_addr;
   logic [imm_width-1:0]      dec_imm;
   queue_e                    dec_queue;
   logic [5:0]                dec_int_opcode;
   ls_op_e                    dec_ls_opcode;
   logic                      dec_needs_tag, dec_is_branch, dec_is_jump, dec_is_load;
   logic [31:0]               dec_jump_target, dec_branch_target;

   logic [data_width-1:0] rf_rs_data, rf_rt_data;
   logic [31:0]           rf_wen_onehot;
   logic [tag_width-1:0]  rst_rs_tag, rst_rt_tag;
   logic                  rst_rs_busy, rst_rt_busy;
   logic [tag_width-1:0]  fifo_head_tag;
   logic                  fifo_empty;

   logic queue_ready, can_dispatch, alloc;
   logic rs_cdb_hit, rt_cdb_hit;

   // Jumps and unknown opcodes need no queue and are never held back
   always_comb begin
      case (dec_queue)
         q_int:   queue_ready = equeue_int_ready;
         q_ls:    queue_ready = equeue_ls_ready;
         q_mult:  queue_ready = equeue_mult_ready;
         q_div:   queue_ready = equeue_div_ready;
         default: queue_ready = 1'b1;
      endcase
   end

   assign can_dispatch = (state == st_dispatch) && !ifq_empty && queue_ready &&
                         (!dec_needs_tag || !fifo_empty);
   assign alloc        = can_dispatch && dec_needs_tag;
   assign ifq_ren      = can_dispatch;

   assign equeue_int_en  = can_dispatch && (dec_queue == q_int);
   assign equeue_ls_en   = can_dispatch && (dec_queue == q_ls);
   assign equeue_mult_en = can_dispatch && (dec_queue == q_mult);
   assign equeue_div_en  = can_dispatch && (dec_queue == q_div);

   // While a branch is pending the only redirect source is the stored target
   assign ifq_branch_addr = (state == st_branch_stall) ? branch_target_r : dec_jump_target;

   always_comb begin
      next_state       = state;
      ifq_branch_valid = 1'b0;
      case (state)
         st_dispatch: begin
            ifq_branch_valid = can_dispatch && dec_is_jump;
            if (can_dispatch && dec_is_branch) begin
               next_state = st_branch_stall;
            end
         end
         st_branch_stall: begin
            if (cdb_branch) begin
               next_state       = st_dispatch;
               ifq_branch_valid = cdb_branch_taken;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_dispatch;
      end else begin
         state <= next_state;
      end
   end

   always_ff @(posedge clk) begin
      if (can_dispatch && dec_is_branch) begin
         branch_target_r <= dec_branch_target;
      end
   end

   // A result on the CDB this cycle resolves a busy operand immediately
   assign rs_cdb_hit = cdb_valid && rst_rs_busy && (rst_rs_tag == cdb_tag);
   assign rt_cdb_hit = cdb_valid && rst_rt_busy && (rst_rt_tag == cdb_tag);

   assign equeue_rsvalid    = !rst_rs_busy || rs_cdb_hit;
   assign equeue_rtvalid    = dec_is_load || !rst_rt_busy || rt_cdb_hit;
   assign equeue_rsdata     = rs_cdb_hit ? cdb_data : rf_rs_data;
   assign equeue_rtdata     = rt_cdb_hit ? cdb_data : rf_rt_data;
   assign equeue_rstag      = rst_rs_tag;
   assign equeue_rttag      = rst_rt_tag;
   assign equeue_rdtag      = fifo_head_tag;
   assign equeue_imm        = dec_imm;
   assign equeue_int_opcode = dec_int_opcode;
   assign equeue_ls_opcode  = dec_ls_opcode;

   inst_decoder u_decoder (
      .inst(ifq_inst), .pc_plus4(ifq_pc_plus4),
      .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr), .dest_addr(dec_dest_addr),
      .imm(dec_imm), .queue(dec_queue),
      .int_opcode(dec_int_opcode), .ls_opcode(dec_ls_opcode),
      .needs_tag(dec_needs_tag), .is_branch(dec_is_branch),
      .is_jump(dec_is_jump), .is_load(dec_is_load),
      .jump_target(dec_jump_target), .branch_target(dec_branch_target)
   );

   regfile u_regfile (
      .clk(clk), .reset(reset),
      .wen_onehot(rf_wen_onehot), .wdata(cdb_data),
      .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
      .rs_data(rf_rs_data), .rt_data(rf_rt_data),
      .debug_addr(debug_regfile_addr), .debug_data(debug_regfile_data)
   );

   reg_status_table #(.tag_width(tag_width)) u_status (
      .clk(clk), .reset(reset),
      .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
      .rs_tag(rst_rs_tag), .rt_tag(rst_rt_tag),
      .rs_busy(rst_rs_busy), .rt_busy(rst_rt_busy),
      .set(alloc), .set_addr(dec_dest_addr), .set_tag(fifo_head_tag),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
      .wen_onehot(rf_wen_onehot)
   );

   tag_fifo #(.tag_width(tag_width)) u_tag_fifo (
      .clk(clk), .reset(reset),
      .pop(alloc), .head_tag(fifo_head_tag), .empty(fifo_empty),
      .cdb_valid(cdb_valid), .cdb_tag(cdb_tag)
   );

endmodule

// File: src/inst_decoder.sv
module inst_decoder (
   input  logic [31:0]                             inst,
   input  logic [31:0]                             pc_plus4,
   output logic [dispatch_pkg::reg_addr_width-1:0] rs_addr,
   output logic [dispatch_pkg::reg_addr_width-1:0] rt_addr,
   output logic [dispatch_pkg::reg_addr_width-1:0] dest_addr,
   output logic [dispatch_pkg::imm_width-1:0]      imm,
   output dispatch_pkg::queue_e                    queue,
   output logic [5:0]                              int_opcode,
   output dispatch_pkg::ls_op_e                    ls_opcode,
   output logic                                    needs_tag,
   output logic                                    is_branch,
   output logic                                    is_jump,
   output logic                                    is_load,
   output logic [31:0]                             jump_target,
   output logic [31:0]                             branch_target
);
   import dispatch_pkg::*;

   opcode_e                   opcode;
   funct_e                    funct;
   logic [reg_addr_width-1:0] rd_addr;
   logic [25:0]               jump_addr;
   logic [31:0]               imm_sext;

   assign opcode    = opcode_e'(inst[31:26]);
   assign rs_addr   = inst[25:21];
   assign rt_addr   = inst[20:16];
   assign rd_addr   = inst[15:11];
   assign funct     = funct_e'(inst[5:0]);
   assign imm       = inst[15:0];
   assign jump_addr = inst[25:0];

   assign imm_sext      = {{(32 - imm_width){imm[imm_width-1]}}, imm};
   assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
   assign jump_target   = {pc_plus4[31:28], jump_addr, 2'b00};

   always_comb begin
      queue      = q_none;
      int_opcode = '0;
      ls_opcode  = ls_lw;
      needs_tag  = 1'b0;
      is_branch  = 1'b0;
      is_jump    = 1'b0;
      is_load    = 1'b0;
      dest_addr  = '0;
      case (opcode)
         op_rtype: begin
            needs_tag = 1'b1;
            dest_addr = rd_addr;
            case (funct)
               fn_mult: queue = q_mult;
               fn_div:  queue = q_div;
               default: begin
                  queue      = q_int;
                  int_opcode = funct;
               end
            endcase
         end
         // Branches go to the integer queue with the major opcode as the op
         op_beq, op_bne: begin
            queue      = q_int;
            int_opcode = opcode;
            is_branch  = 1'b1;
         end
         op_j: is_jump = 1'b1;
         op_lw: begin
            queue     = q_ls;
            needs_tag = 1'b1;
            is_load   = 1'b1;
            dest_addr = rt_addr;
         end
         op_sw: begin
            queue     = q_ls;
            ls_opcode = ls_sw;
         end
         default: queue = q_none;
      endcase
   end

endmodule

// File: src/tag_fifo.sv
module tag_fifo #(
   parameter int tag_width = 6
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 pop,
   output logic [tag_width-1:0] head_tag,
   output logic                 empty,
   input  logic                 cdb_valid,
   input  logic [tag_width-1:0] cdb_tag
);

   localparam int num_tags = 2 ** tag_width;

   logic [tag_width-1:0] mem [num_tags];
   logic [tag_width-1:0] rd_ptr;
   logic [tag_width-1:0] wr_ptr;
   logic [tag_width:0]   count;
   logic                 do_pop;

   assign empty    = (count == '0);
   assign head_tag = mem[rd_ptr];
   assign do_pop   = pop && !empty;

   // The list starts full, so the write pointer wraps back onto slot 0
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (tag_width + 1)'(num_tags);
         for (int i = 0; i < num_tags; i++) begin
            mem[i] <= tag_width'(i);
         end
      end else begin
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (cdb_valid) begin
            mem[wr_ptr] <= cdb_tag;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         case ({cdb_valid, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: src/reg_status_table.sv
module reg_status_table #(
   parameter int tag_width = 6
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [dispatch_pkg::reg_addr_width-1:0] rs_addr,
   input  logic [dispatch_pkg::reg_addr_width-1:0] rt_addr,
   output logic [tag_width-1:0]                    rs_tag,
   output logic [tag_width-1:0]                    rt_tag,
   output logic                                    rs_busy,
   output logic                                    rt_busy,
   input  logic                                    set,
   input  logic [dispatch_pkg::reg_addr_width-1:0] set_addr,
   input  logic [tag_width-1:0]                    set_tag,
   input  logic                                    cdb_valid,
   input  logic [tag_width-1:0]                    cdb_tag,
   output logic [31:0]                             wen_onehot
);
   import dispatch_pkg::*;

   localparam int num_regs = 2 ** reg_addr_width;

   logic [num_regs-1:0]  busy;
   logic [tag_width-1:0] tags [num_regs];

   // Every busy register waiting on the broadcast tag takes the CDB data
   always_comb begin
      for (int i = 0; i < num_regs; i++) begin
         wen_onehot[i] = cdb_valid && busy[i] && (tags[i] == cdb_tag);
      end
   end

   // A new allocation overrides a CDB clear of the same register
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= '0;
      end else begin
         for (int i = 1; i < num_regs; i++) begin
            if (set && (set_addr == reg_addr_width'(i))) begin
               busy[i] <= 1'b1;
               tags[i] <= set_tag;
            end else if (wen_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];
   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];

endmodule

// File: src/regfile.sv
module regfile (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [31:0]                             wen_onehot,
   input  logic [dispatch_pkg::data_width-1:0]     wdata,
   input  logic [dispatch_pkg::reg_addr_width-1:0] rs_addr,
   input  logic [dispatch_pkg::reg_addr_width-1:0] rt_addr,
   output logic [dispatch_pkg::data_width-1:0]     rs_data,
   output logic [dispatch_pkg::data_width-1:0]     rt_data,
   input  logic [dispatch_pkg::reg_addr_width-1:0] debug_addr,
   output logic [dispatch_pkg::data_width-1:0]     debug_data
);
   import dispatch_pkg::*;

   localparam int num_regs = 2 ** reg_addr_width;

   logic [data_width-1:0] regs [num_regs];

   // Register 0 is only ever written by reset, so it stays zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 1; i < num_regs; i++) begin
            if (wen_onehot[i]) begin
               regs[i] <= wdata;
            end
         end
      end
   end

   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

endmodule

// File: src/dispatch_pkg.sv
package dispatch_pkg;

   // Instruction field widths
   localparam int data_width     = 32;
   localparam int reg_addr_width = 5;
   localparam int imm_width      = 16;
   localparam int opcode_width   = 6;

   // MIPS major opcodes handled by dispatch
   typedef enum logic [opcode_width-1:0] {
      op_rtype = 6'd0,
      op_j     = 6'd2,
      op_beq   = 6'd4,
      op_bne   = 6'd5,
      op_lw    = 6'd35,
      op_sw    = 6'd43
   } opcode_e;

   // R-type function codes that leave the integer queue
   typedef enum logic [5:0] {
      fn_mult = 6'd24,
      fn_div  = 6'd26
   } funct_e;

   typedef enum logic [2:0] {
      q_none,
      q_int,
      q_ls,
      q_mult,
      q_div
   } queue_e;

   typedef enum logic {
      ls_lw = 1'b0,
      ls_sw = 1'b1
   } ls_op_e;

   typedef enum logic {
      st_dispatch,
      st_branch_stall
   } dispatch_state_e;

endpackage
